//--- list.f
+incdir+design
design/ac_range_check_bus_pkg.sv
design/ac_range_check_reg_pkg.sv
design/ac_range_check_reg_top.sv
design/ac_range_check_filter.sv
design/ac_range_check.sv
sim/tb_ac_range_check.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_ac_range_check \
  -o tb_ac_range_check

output=$(./obj_dir/tb_ac_range_check)
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

//--- sim/tb_ac_range_check.sv
// ####################################################################
// Access range checker testbench with host and target models,
// CSR tasks, timing and forwarding assertions and a cycle timeout
// ####################################################################

`timescale 1ns/100ps
`default_nettype none

`include "ac_range_check_defines.svh"

module tb_ac_range_check;
  import ac_range_check_reg_pkg::*;
  import ac_range_check_bus_pkg::*;

  // About 60 bus and CSR operations of under 12 cycles each plus margin
  localparam int CycleLimit = 2000;
  localparam logic [`AC_DATA_W-1:0] TgtMask = 32'hA5A5A5A5;

  logic                  clk;
  logic                  rst_n;
  csr_req_t              csr_req;
  csr_rsp_t              csr_rsp;
  bus_req_t              host_req;
  bus_rsp_t              host_rsp;
  bus_req_t              tgt_req;
  bus_rsp_t              tgt_rsp;
  logic                  overwrite;
  logic                  intr;
  logic                  exp_allow;
  int                    errors = 0;
  int                    cycle_cnt;
  int                    tgt_wait;
  logic [`AC_ADDR_W-1:0] tgt_addr;
  logic [`AC_DATA_W-1:0] rd_data;
  logic                  rd_err;
  int unsigned           seed_val;

  ac_range_check u_ac_range_check (
    .clk_i                   (clk),
    .rst_n_i                 (rst_n),
    .csr_req_i               (csr_req),
    .csr_rsp_o               (csr_rsp),
    .ctn_req_i               (host_req),
    .ctn_rsp_o               (host_rsp),
    .ctn_filtered_req_o      (tgt_req),
    .ctn_filtered_rsp_i      (tgt_rsp),
    .range_check_overwrite_i (overwrite),
    .intr_deny_cnt_reached_o (intr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Target answers every forwarded request 2 to 5 cycles later
  initial begin
    seed_val = $urandom(624);
    tgt_rsp  <= '0;
    tgt_wait = 0;
    tgt_addr = '0;
    forever begin
      @(posedge clk);
      tgt_rsp.valid <= 1'b0;
      if (tgt_req.valid) begin
        tgt_wait = 1 + int'($urandom % 4);
        tgt_addr = tgt_req.addr;
      end else if (tgt_wait > 1) begin
        tgt_wait = tgt_wait - 1;
      end else if (tgt_wait == 1) begin
        tgt_wait = 0;
        tgt_rsp <= '{valid: 1'b1, rdata: tgt_addr ^ TgtMask, error: 1'b0};
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) csr_req.valid |=> csr_rsp.valid)
    else begin
      errors++;
      $display("CSR response did not come one cycle after its request");
    end

  assert property (@(posedge clk) disable iff (!rst_n) csr_rsp.valid |-> $past(csr_req.valid))
    else begin
      errors++;
      $display("CSR response came without a request");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   host_req.valid && exp_allow |=> tgt_req.valid && tgt_req == $past(host_req))
    else begin
      errors++;
      $display("Allowed request was not forwarded unchanged one cycle later");
    end

  // Squashed request is answered locally and never reaches the target
  assert property (@(posedge clk) disable iff (!rst_n)
                   host_req.valid && !exp_allow |=>
                   host_rsp.valid && host_rsp.error && host_rsp.rdata == '0 && !tgt_req.valid)
    else begin
      errors++;
      $display("Denied request did not get a local error response one cycle later");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   tgt_req.valid |-> $past(host_req.valid && exp_allow))
    else begin
      errors++;
      $display("Target saw a request that should have been squashed");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   tgt_rsp.valid |-> host_rsp.valid && !host_rsp.error &&
                   host_rsp.rdata == tgt_rsp.rdata)
    else begin
      errors++;
      $display("Target response was not passed back to the host");
    end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic csr_write(input logic [7:0] offset, input logic [31:0] data);
    @(posedge clk);
    csr_req <= '{valid: 1'b1, we: 1'b1, addr: offset, wdata: data};
    @(posedge clk);
    csr_req.valid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic csr_read(input logic [7:0] offset, output logic [31:0] data, output logic err);
    @(posedge clk);
    csr_req <= '{valid: 1'b1, we: 1'b0, addr: offset, wdata: '0};
    @(posedge clk);
    csr_req.valid <= 1'b0;
    @(negedge clk);
    data = csr_rsp.rdata;
    err  = csr_rsp.error;
  endtask

  task automatic csr_expect(input string name, input logic [7:0] offset, input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    csr_read(offset, data, err);
    check_value(name, exp, data);
    check_value({name, " error"}, 32'd0, 32'(err));
  endtask

  // One host request that returns once the host sees its response
  task automatic host_access(input access_e acc, input logic [31:0] addr, input logic allow,
                             output bus_rsp_t rsp_out);
    @(posedge clk);
    host_req  <= '{valid: 1'b1, access: acc, addr: addr, wdata: addr ^ 32'h0F0F0F0F};
    exp_allow <= allow;
    @(posedge clk);
    host_req.valid <= 1'b0;
    @(negedge clk);
    while (!host_rsp.valid) begin
      @(negedge clk);
    end
    rsp_out = host_rsp;
  endtask

  task automatic expect_allow(input string name, input access_e acc, input logic [31:0] addr);
    bus_rsp_t rsp;
    host_access(acc, addr, 1'b1, rsp);
    check_value({name, " rdata"}, addr ^ TgtMask, rsp.rdata);
    check_value({name, " error"}, 32'd0, 32'(rsp.error));
  endtask

  task automatic expect_deny(input string name, input access_e acc, input logic [31:0] addr);
    bus_rsp_t rsp;
    host_access(acc, addr, 1'b0, rsp);
    check_value({name, " error"}, 32'd1, 32'(rsp.error));
  endtask

  // Interrupt state lands one cycle after the deny response
  task automatic check_intr(input string name, input logic exp);
    @(negedge clk);
    check_value(name, 32'(exp), 32'(intr));
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n     <= 1'b0;
    csr_req   <= '0;
    host_req  <= '0;
    overwrite <= 1'b0;
    exp_allow <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // CSR access
    csr_write(8'h20, 32'h0000_1000);
    csr_write(8'h24, 32'h0000_2000);
    csr_write(8'h28, 32'h3);
    csr_expect("range0 base", 8'h20, 32'h0000_1000);
    csr_expect("range0 limit", 8'h24, 32'h0000_2000);
    csr_expect("range0 attr", 8'h28, 32'h3);
    csr_write(DENY_THRESH_OFFSET, 32'h5A);
    csr_expect("deny thresh", DENY_THRESH_OFFSET, 32'h5A);
    csr_write(INTR_ENABLE_OFFSET, 32'h1);
    csr_expect("intr enable", INTR_ENABLE_OFFSET, 32'h1);
    csr_write(INTR_ENABLE_OFFSET, 32'h0);
    csr_read(8'h1C, rd_data, rd_err);
    check_value("unmapped 0x1C error", 32'd1, 32'(rd_err));
    csr_read(8'h60, rd_data, rd_err);
    check_value("unmapped 0x60 error", 32'd1, 32'(rd_err));

    // Allowed forwarding up to the exclusive limit
    expect_allow("read inside range0", ACC_READ, 32'h0000_1800);
    expect_allow("read at range0 base", ACC_READ, 32'h0000_1000);
    expect_deny("read at range0 limit", ACC_READ, 32'h0000_2000);

    // Denial, counter and first-denial log
    csr_write(DENY_CNT_OFFSET, 32'h0);
    csr_write(LOG_STATUS_OFFSET, 32'h0);
    expect_deny("write to read-only range", ACC_WRITE, 32'h0000_1400);
    csr_expect("deny cnt after one", DENY_CNT_OFFSET, 32'd1);
    expect_deny("exec outside ranges", ACC_EXEC, 32'h0000_8000);
    expect_deny("read outside ranges", ACC_READ, 32'h0000_9000);
    csr_expect("deny cnt after three", DENY_CNT_OFFSET, 32'd3);
    csr_expect("log addr", LOG_ADDR_OFFSET, 32'h0000_1400);
    csr_expect("log status", LOG_STATUS_OFFSET, {29'd0, ACC_WRITE, 1'b1});
    csr_write(LOG_STATUS_OFFSET, 32'h0);
    csr_expect("log status cleared", LOG_STATUS_OFFSET, 32'h0);
    expect_deny("read after log clear", ACC_READ, 32'h0000_9000);
    csr_expect("log addr relogged", LOG_ADDR_OFFSET, 32'h0000_9000);
    csr_expect("log status relogged", LOG_STATUS_OFFSET, {29'd0, ACC_READ, 1'b1});

    // Overlap of range 1 (write only) and range 2 (read only)
    csr_write(8'h30, 32'h0000_4000);
    csr_write(8'h34, 32'h0000_6000);
    csr_write(8'h38, 32'h5);
    csr_write(8'h40, 32'h0000_5000);
    csr_write(8'h44, 32'h0000_7000);
    csr_write(8'h48, 32'h3);
    expect_deny("read in overlap", ACC_READ, 32'h0000_5800);
    expect_allow("write in overlap", ACC_WRITE, 32'h0000_5800);
    expect_allow("read in range2 only", ACC_READ, 32'h0000_6800);
    expect_deny("write in range2 only", ACC_WRITE, 32'h0000_6800);

    // Threshold interrupt
    csr_write(DENY_CNT_OFFSET, 32'h0);
    csr_write(INTR_STATE_OFFSET, 32'h1);
    csr_write(DENY_THRESH_OFFSET, 32'd3);
    csr_write(INTR_ENABLE_OFFSET, 32'h1);
    expect_deny("intr deny 1", ACC_READ, 32'h0000_9000);
    check_intr("intr after deny 1", 1'b0);
    expect_deny("intr deny 2", ACC_READ, 32'h0000_9000);
    check_intr("intr after deny 2", 1'b0);
    expect_deny("intr deny 3", ACC_READ, 32'h0000_9000);
    check_intr("intr after deny 3", 1'b1);
    expect_deny("intr deny 4", ACC_READ, 32'h0000_9000);
    check_intr("intr after deny 4", 1'b1);
    csr_write(INTR_STATE_OFFSET, 32'h1);
    check_intr("intr after clear", 1'b0);
    csr_write(INTR_ENABLE_OFFSET, 32'h0);
    csr_write(DENY_CNT_OFFSET, 32'h0);
    for (int k = 0; k < 3; k++) begin
      expect_deny("masked deny", ACC_READ, 32'h0000_9000);
      check_intr("intr masked", 1'b0);
    end
    csr_expect("intr state masked", INTR_STATE_OFFSET, 32'h1);

    // Overwrite lets everything through without counting
    csr_expect("deny cnt before overwrite", DENY_CNT_OFFSET, 32'd3);
    @(posedge clk);
    overwrite <= 1'b1;
    expect_allow("overwrite read", ACC_READ, 32'h0000_9000);
    expect_allow("overwrite exec", ACC_EXEC, 32'h0000_F000);
    expect_allow("overwrite write", ACC_WRITE, 32'h0000_1400);
    @(posedge clk);
    overwrite <= 1'b0;
    csr_expect("deny cnt under overwrite", DENY_CNT_OFFSET, 32'd3);

    repeat (2) @(posedge clk);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/ac_range_check.sv
// ####################################################################
// Access range checker top: register block beside the request filter
// ####################################################################

`timescale 1ns/100ps
`default_nettype none

`include "ac_range_check_defines.svh"

module ac_range_check (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // CSR port
  input  ac_range_check_reg_pkg::csr_req_t csr_req_i,
  output ac_range_check_reg_pkg::csr_rsp_t csr_rsp_o,
  // Unfiltered host side
  input  ac_range_check_bus_pkg::bus_req_t ctn_req_i,
  output ac_range_check_bus_pkg::bus_rsp_t ctn_rsp_o,
  // Filtered target side
  output ac_range_check_bus_pkg::bus_req_t ctn_filtered_req_o,
  input  ac_range_check_bus_pkg::bus_rsp_t ctn_filtered_rsp_i,
  input  logic                             range_check_overwrite_i,
  output logic                             intr_deny_cnt_reached_o
);
  import ac_range_check_reg_pkg::*;

  range_cfg_t [`AC_NUM_RANGES-1:0] range_cfg;
  deny_evt_t                       deny_evt;

  ac_range_check_reg_top u_reg_top (
    .clk_i                   (clk_i),
    .rst_n_i                 (rst_n_i),
    .csr_req_i               (csr_req_i),
    .csr_rsp_o               (csr_rsp_o),
    .deny_evt_i              (deny_evt),
    .range_cfg_o             (range_cfg),
    .intr_deny_cnt_reached_o (intr_deny_cnt_reached_o)
  );

  ac_range_check_filter u_filter (
    .clk_i                   (clk_i),
    .rst_n_i                 (rst_n_i),
    .ctn_req_i               (ctn_req_i),
    .ctn_rsp_o               (ctn_rsp_o),
    .ctn_filtered_req_o      (ctn_filtered_req_o),
    .ctn_filtered_rsp_i      (ctn_filtered_rsp_i),
    .range_cfg_i             (range_cfg),
    .range_check_overwrite_i (range_check_overwrite_i),
    .deny_evt_o              (deny_evt)
  );

endmodule

`default_nettype wire

//--- design/ac_range_check_filter.sv
// ####################################################################
// Request filter: parallel range match, priority pick, forwarding
// of allowed requests and error squashing of denied ones
// ####################################################################

`timescale 1ns/100ps
`default_nettype none

`include "ac_range_check_defines.svh"

module ac_range_check_filter (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  ac_range_check_bus_pkg::bus_req_t                        ctn_req_i,
  output ac_range_check_bus_pkg::bus_rsp_t                        ctn_rsp_o,
  output ac_range_check_bus_pkg::bus_req_t                        ctn_filtered_req_o,
  input  ac_range_check_bus_pkg::bus_rsp_t                        ctn_filtered_rsp_i,
  input  ac_range_check_reg_pkg::range_cfg_t [`AC_NUM_RANGES-1:0] range_cfg_i,
  input  logic                                                    range_check_overwrite_i,
  output ac_range_check_reg_pkg::deny_evt_t                       deny_evt_o
);
  import ac_range_check_bus_pkg::*;

  logic [`AC_NUM_RANGES-1:0] range_hit;
  logic [`AC_NUM_RANGES-1:0] range_perm;
  logic                      range_allow;
  logic                      req_allow;

  bus_req_t req_q;
  logic     fwd_q;
  logic     deny_q;
  logic     pending_q;
  logic     rsp_accept;

  // All ranges are compared at once
  always_comb begin
    for (int i = 0; i < `AC_NUM_RANGES; i++) begin
      range_hit[i] = range_cfg_i[i].enable &&
                     (ctn_req_i.addr >= range_cfg_i[i].base) &&
                     (ctn_req_i.addr <  range_cfg_i[i].limit);
      case (ctn_req_i.access)
        ACC_READ:  range_perm[i] = range_cfg_i[i].read_ok;
        ACC_WRITE: range_perm[i] = range_cfg_i[i].write_ok;
        ACC_EXEC:  range_perm[i] = range_cfg_i[i].exec_ok;
        default:   range_perm[i] = 1'b0;
      endcase
    end
  end

  // Walk down so that the lowest matching index has the last word.
  // No hit at all leaves the request denied.
  always_comb begin
    range_allow = 1'b0;
    for (int i = `AC_NUM_RANGES - 1; i >= 0; i--) begin
      if (range_hit[i]) begin
        range_allow = range_perm[i];
      end
    end
  end

  assign req_allow = range_check_overwrite_i || range_allow;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fwd_q  <= 1'b0;
      deny_q <= 1'b0;
    end else begin
      fwd_q  <= ctn_req_i.valid && req_allow;
      deny_q <= ctn_req_i.valid && !req_allow;
    end
  end

  // Request payload, held for forwarding or for the deny event
  always_ff @(posedge clk_i) begin
    if (ctn_req_i.valid) begin
      req_q <= ctn_req_i;
    end
  end

  // Only the response to our forwarded request goes back
  assign rsp_accept = ctn_filtered_rsp_i.valid && (pending_q || fwd_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else if (rsp_accept) begin
      pending_q <= 1'b0;
    end else if (fwd_q) begin
      pending_q <= 1'b1;
    end
  end

  always_comb begin
    ctn_filtered_req_o       = req_q;
    ctn_filtered_req_o.valid = fwd_q;
  end

  // Squashed requests get a local error response
  always_comb begin
    ctn_rsp_o       = ctn_filtered_rsp_i;
    ctn_rsp_o.valid = rsp_accept;
    if (deny_q) begin
      ctn_rsp_o.valid = 1'b1;
      ctn_rsp_o.rdata = '0;
      ctn_rsp_o.error = 1'b1;
    end
  end

  assign deny_evt_o.valid  = deny_q;
  assign deny_evt_o.addr   = req_q.addr;
  assign deny_evt_o.access = req_q.access;

endmodule

`default_nettype wire

//--- design/ac_range_check_reg_top.sv
// ####################################################################
// CSR block: offset decode, range registers, deny counter with
// threshold interrupt and log of the first denied access
// ####################################################################

`timescale 1ns/100ps
`default_nettype none

`include "ac_range_check_defines.svh"

module ac_range_check_reg_top (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  ac_range_check_reg_pkg::csr_req_t                       csr_req_i,
  output ac_range_check_reg_pkg::csr_rsp_t                       csr_rsp_o,
  input  ac_range_check_reg_pkg::deny_evt_t                      deny_evt_i,
  output ac_range_check_reg_pkg::range_cfg_t [`AC_NUM_RANGES-1:0] range_cfg_o,
  output logic                                                   intr_deny_cnt_reached_o
);
  import ac_range_check_reg_pkg::*;
  import ac_range_check_bus_pkg::*;

  localparam int unsigned DataW = `AC_DATA_W;

  range_cfg_t [`AC_NUM_RANGES-1:0] range_q;
  logic                             intr_state_q;
  logic                             intr_enable_q;
  logic [`AC_DENY_CNT_W-1:0]        deny_thresh_q;
  logic [`AC_DENY_CNT_W-1:0]        deny_cnt_q;
  logic                             log_valid_q;
  logic [`AC_ADDR_W-1:0]            log_addr_q;
  access_e                          log_access_q;

  logic                      csr_wr;
  logic                      csr_hit;
  logic [DataW-1:0]          csr_rdata;
  logic [`AC_NUM_RANGES-1:0] base_hit;
  logic [`AC_NUM_RANGES-1:0] limit_hit;
  logic [`AC_NUM_RANGES-1:0] attr_hit;
  logic                      cnt_inc;
  logic                      cnt_reached;
  logic                      rsp_valid_q;
  logic                      rsp_error_q;
  logic [DataW-1:0]          rsp_rdata_q;

  assign csr_wr = csr_req_i.valid && csr_req_i.we;

  // Offset decode and read mux
  always_comb begin
    csr_hit   = 1'b1;
    csr_rdata = '0;
    case (csr_req_i.addr)
      INTR_STATE_OFFSET:  csr_rdata = DataW'(intr_state_q);
      INTR_ENABLE_OFFSET: csr_rdata = DataW'(intr_enable_q);
      DENY_THRESH_OFFSET: csr_rdata = DataW'(deny_thresh_q);
      DENY_CNT_OFFSET:    csr_rdata = DataW'(deny_cnt_q);
      LOG_ADDR_OFFSET:    csr_rdata = DataW'(log_addr_q);
      LOG_STATUS_OFFSET:  csr_rdata = DataW'({log_access_q, log_valid_q});
      default:            csr_hit   = 1'b0;
    endcase
    for (int i = 0; i < `AC_NUM_RANGES; i++) begin
      base_hit[i]  = csr_req_i.addr == 8'(RANGE_BASE_OFFSET + RANGE_STRIDE * i);
      limit_hit[i] = csr_req_i.addr == 8'(RANGE_LIMIT_OFFSET + RANGE_STRIDE * i);
      attr_hit[i]  = csr_req_i.addr == 8'(RANGE_ATTR_OFFSET + RANGE_STRIDE * i);
      if (base_hit[i]) begin
        csr_hit   = 1'b1;
        csr_rdata = DataW'(range_q[i].base);
      end
      if (limit_hit[i]) begin
        csr_hit   = 1'b1;
        csr_rdata = DataW'(range_q[i].limit);
      end
      if (attr_hit[i]) begin
        csr_hit   = 1'b1;
        csr_rdata = DataW'({range_q[i].exec_ok, range_q[i].write_ok,
                            range_q[i].read_ok, range_q[i].enable});
      end
    end
  end

  // Range configuration
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      range_q <= '0;
    end else if (csr_wr) begin
      for (int i = 0; i < `AC_NUM_RANGES; i++) begin
        if (base_hit[i]) begin
          range_q[i].base <= csr_req_i.wdata[`AC_ADDR_W-1:0];
        end
        if (limit_hit[i]) begin
          range_q[i].limit <= csr_req_i.wdata[`AC_ADDR_W-1:0];
        end
        if (attr_hit[i]) begin
          range_q[i].enable   <= csr_req_i.wdata[0];
          range_q[i].read_ok  <= csr_req_i.wdata[1];
          range_q[i].write_ok <= csr_req_i.wdata[2];
          range_q[i].exec_ok  <= csr_req_i.wdata[3];
        end
      end
    end
  end

  assign range_cfg_o = range_q;

  // Saturating count, interrupt fires on the increment that hits the threshold
  assign cnt_inc     = deny_evt_i.valid && (deny_cnt_q != '1);
  assign cnt_reached = cnt_inc && (deny_thresh_q != '0) && (deny_cnt_q + 1'b1 == deny_thresh_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      intr_state_q  <= 1'b0;
      intr_enable_q <= 1'b0;
      deny_thresh_q <= '0;
      deny_cnt_q    <= '0;
    end else begin
      if (csr_wr && csr_req_i.addr == INTR_ENABLE_OFFSET) begin
        intr_enable_q <= csr_req_i.wdata[0];
      end
      if (csr_wr && csr_req_i.addr == DENY_THRESH_OFFSET) begin
        deny_thresh_q <= csr_req_i.wdata[`AC_DENY_CNT_W-1:0];
      end
      if (csr_wr && csr_req_i.addr == DENY_CNT_OFFSET) begin
        deny_cnt_q <= '0;
      end else if (cnt_inc) begin
        deny_cnt_q <= deny_cnt_q + 1'b1;
      end
      // A new hit wins over a clear in the same cycle
      if (cnt_reached) begin
        intr_state_q <= 1'b1;
      end else if (csr_wr && csr_req_i.addr == INTR_STATE_OFFSET && csr_req_i.wdata[0]) begin
        intr_state_q <= 1'b0;
      end
    end
  end

  assign intr_deny_cnt_reached_o = intr_state_q && intr_enable_q;

  // First denial log
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      log_valid_q  <= 1'b0;
      log_addr_q   <= '0;
      log_access_q <= ACC_READ;
    end else if (csr_wr && csr_req_i.addr == LOG_STATUS_OFFSET) begin
      log_valid_q  <= 1'b0;
      log_addr_q   <= '0;
      log_access_q <= ACC_READ;
    end else if (deny_evt_i.valid && !log_valid_q) begin
      log_valid_q  <= 1'b1;
      log_addr_q   <= deny_evt_i.addr;
      log_access_q <= deny_evt_i.access;
    end
  end

  // Registered CSR response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_error_q <= 1'b0;
    end else begin
      rsp_valid_q <= csr_req_i.valid;
      rsp_error_q <= csr_req_i.valid && !csr_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_rdata_q <= (csr_req_i.we || !csr_hit) ? '0 : csr_rdata;
  end

  assign csr_rsp_o.valid = rsp_valid_q;
  assign csr_rsp_o.rdata = rsp_rdata_q;
  assign csr_rsp_o.error = rsp_error_q;

endmodule

`default_nettype wire

//--- design/ac_range_check_reg_pkg.sv
// ####################################################################
// Register map offsets, range configuration, deny event and CSR types
// ####################################################################

`default_nettype none

`include "ac_range_check_defines.svh"

package ac_range_check_reg_pkg;

  // Byte offsets of the CSR map
  localparam logic [7:0] INTR_STATE_OFFSET  = 8'h00;
  localparam logic [7:0] INTR_ENABLE_OFFSET = 8'h04;
  localparam logic [7:0] DENY_THRESH_OFFSET = 8'h08;
  localparam logic [7:0] DENY_CNT_OFFSET    = 8'h0C;
  localparam logic [7:0] LOG_ADDR_OFFSET    = 8'h10;
  localparam logic [7:0] LOG_STATUS_OFFSET  = 8'h14;
  // Per-range block, one stride per range
  localparam logic [7:0] RANGE_BASE_OFFSET  = 8'h20;
  localparam logic [7:0] RANGE_LIMIT_OFFSET = 8'h24;
  localparam logic [7:0] RANGE_ATTR_OFFSET  = 8'h28;
  localparam logic [7:0] RANGE_STRIDE       = 8'h10;

  typedef struct packed {
    logic [`AC_ADDR_W-1:0] base;
    logic [`AC_ADDR_W-1:0] limit;
    logic                  enable;
    logic                  read_ok;
    logic                  write_ok;
    logic                  exec_ok;
  } range_cfg_t;

  // One-cycle pulse per squashed request
  typedef struct packed {
    logic                            valid;
    logic [`AC_ADDR_W-1:0]           addr;
    ac_range_check_bus_pkg::access_e access;
  } deny_evt_t;

  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [7:0]            addr;
    logic [`AC_DATA_W-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`AC_DATA_W-1:0] rdata;
    logic                  error;
  } csr_rsp_t;

endpackage

`default_nettype wire

//--- design/ac_range_check_bus_pkg.sv
// ####################################################################
// Bus types: access kind enum, host request and response structs
// ####################################################################

`default_nettype none

`include "ac_range_check_defines.svh"

package ac_range_check_bus_pkg;

  // Kind of access carried by a host request
  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } access_e;

  // Request, valid is a single-cycle pulse
  typedef struct packed {
    logic                  valid;
    access_e               access;
    logic [`AC_ADDR_W-1:0] addr;
    logic [`AC_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`AC_DATA_W-1:0] rdata;
    logic                  error;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- design/ac_range_check_defines.svh
// ####################################################################
// Sizing macros for the access range checker: range count,
// bus address and data widths, deny counter width
// ####################################################################

`ifndef AC_RANGE_CHECK_DEFINES_SVH
`define AC_RANGE_CHECK_DEFINES_SVH

// Number of programmable address ranges
`define AC_NUM_RANGES 4

// Host and target bus address width
`define AC_ADDR_W 32

// Bus and CSR data width
`define AC_DATA_W 32

// Deny counter and threshold width
`define AC_DENY_CNT_W 8

`endif
